// File: hw/fetch_pkg.sv
package fetch_pkg;

    // Widths of the fetch path.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Bit positions inside a fault code.
    localparam int FAULT_PAGE = 0;
    localparam int FAULT_XES  = 1;

    // Byte address, used for every PC and redirect target.
    typedef logic [ADDR_W-1:0] addr_t;

    // One instruction word.
    typedef logic [DATA_W-1:0] inst_t;

    // Fault code returned with each word, bit 1 access and bit 0 page.
    typedef logic [1:0] fault_t;

    // Step between sequential fetches.
    localparam addr_t PC_STEP = addr_t'(4);

endpackage

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic redirect,
    input  logic busy,
    input  logic stall,
    output logic imem_req,
    output logic inst_valid,
    output logic buf_load,
    output logic buf_sel
);

    logic pending;   // A request is out and its word not yet delivered.
    logic buf_valid; // Buffer holds a word that decode has not taken.
    logic arrived;

    // Memory data belongs to the pending request once busy drops.
    assign arrived = pending & ~busy;

    // One request at a time. A new one may go out in the delivery cycle.
    assign imem_req = ~busy & ~redirect & (inst_valid | ~pending);

    assign inst_valid = (arrived | buf_valid) & ~stall & ~redirect;

    // Catch the word when decode cannot take it.
    assign buf_load = arrived & stall & ~buf_valid & ~redirect;

    assign buf_sel = buf_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (redirect) begin
            pending <= 1'b0; // Late data from this request is ignored.
        end else if (imem_req) begin
            pending <= 1'b1;
        end else if (inst_valid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_valid <= 1'b0;
        end else if (redirect) begin
            buf_valid <= 1'b0;
        end else if (buf_load) begin
            buf_valid <= 1'b1;
        end else if (inst_valid) begin
            buf_valid <= 1'b0;
        end
    end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  eret_en,
    input  addr_t ret_epc,
    input  logic  irq_en,
    input  addr_t irq_vec,
    input  logic  alu_en,
    input  addr_t alu_target,
    input  logic  jump_en,
    input  addr_t jump_target,
    input  logic  advance,
    input  logic  deliver,
    output logic  redirect,
    output addr_t fetch_pc,
    output addr_t pc
);

    addr_t target;
    addr_t fetch_pc_nxt;

    assign redirect = eret_en | irq_en | alu_en | jump_en;

    // Exception return first, then interrupt, ALU branch, jump.
    assign target = eret_en ? ret_epc    :
                    irq_en  ? irq_vec    :
                    alu_en  ? alu_target :
                              jump_target;

    assign fetch_pc_nxt = redirect ? target : fetch_pc + PC_STEP;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc <= RESET_PC;
        end else if (advance | redirect) begin
            fetch_pc <= fetch_pc_nxt;
        end
    end

    // PC of the word handed to decode. Lags the fetch PC by one request.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (deliver) begin
            pc <= fetch_pc;
        end
    end

endmodule

// File: hw/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  inst_t  rdata,
    input  fault_t bad,
    input  logic   busy,
    input  logic   buf_load,
    input  logic   buf_sel,
    output inst_t  inst,
    output fault_t fault
);

    inst_t  inst_q;
    fault_t fault_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_q  <= '0;
            fault_q <= '0;
        end else if (buf_load) begin
            inst_q  <= rdata;
            fault_q <= bad;
        end
    end

    // Held word wins, then live memory data.
    always_comb begin
        if (buf_sel) begin
            inst  = inst_q;
            fault = fault_q;
        end else if (!busy) begin
            inst  = rdata;
            fault = bad;
        end else begin
            inst  = '0;
            fault = '0;
        end
    end

endmodule

// File: hw/imem.sv
`timescale 1ns/1ps

module imem import fetch_pkg::*; #(
    parameter int    MEM_WORDS   = 32,
    parameter addr_t NX_BASE     = addr_t'(32'h60),
    parameter int    WAIT_CYCLES = 1
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   req,
    input  addr_t  addr,
    output logic   busy,
    output inst_t  rdata,
    output fault_t bad
);

    localparam int    IDX_W   = $clog2(MEM_WORDS);
    localparam int    CNT_W   = $clog2(WAIT_CYCLES + 1);
    localparam addr_t MAP_END = addr_t'(MEM_WORDS * 4);

    inst_t             rom [MEM_WORDS];
    addr_t             addr_q;
    logic [CNT_W-1:0]  wait_cnt;
    logic [IDX_W-1:0]  idx;

    initial begin
        $readmemh("dv/imem.hex", rom);
    end

    // Latch the address and start the wait count.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_q   <= '0;
            wait_cnt <= '0;
        end else if (req) begin
            addr_q   <= addr;
            wait_cnt <= CNT_W'(WAIT_CYCLES);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign busy = (wait_cnt != '0);
    assign idx  = addr_q[IDX_W+1:2]; // Word index, byte offset dropped.

    always_comb begin
        bad = '0;
        if (addr_q >= MAP_END) begin
            rdata           = '0; // Unmapped.
            bad[FAULT_PAGE] = 1'b1;
        end else begin
            rdata = rom[idx];
            if (addr_q >= NX_BASE) begin
                bad[FAULT_XES] = 1'b1; // Data still returned.
            end
        end
    end

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter addr_t RESET_PC    = '0,
    parameter int    MEM_WORDS   = 32,
    parameter addr_t NX_BASE     = addr_t'(32'h60),
    parameter int    WAIT_CYCLES = 1
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  eret_en,
    input  addr_t ret_epc,
    input  logic  irq_en,
    input  addr_t irq_vec,
    input  logic  alu_en,
    input  addr_t alu_target,
    input  logic  jump_en,
    input  addr_t jump_target,
    input  logic  stall,
    output addr_t pc,
    output inst_t inst,
    output logic  inst_valid,
    output logic  page_fault,
    output logic  xes_fault
);

    logic   redirect;
    logic   imem_req;
    addr_t  imem_addr;
    logic   busy;
    inst_t  rdata;
    fault_t bad;
    logic   buf_load;
    logic   buf_sel;
    fault_t fault;

    fetch_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .redirect   (redirect),
        .busy       (busy),
        .stall      (stall),
        .imem_req   (imem_req),
        .inst_valid (inst_valid),
        .buf_load   (buf_load),
        .buf_sel    (buf_sel)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk         (clk),
        .rstn        (rstn),
        .eret_en     (eret_en),
        .ret_epc     (ret_epc),
        .irq_en      (irq_en),
        .irq_vec     (irq_vec),
        .alu_en      (alu_en),
        .alu_target  (alu_target),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .advance     (imem_req),
        .deliver     (inst_valid),
        .redirect    (redirect),
        .fetch_pc    (imem_addr),
        .pc          (pc)
    );

    inst_buffer u_buf (
        .clk      (clk),
        .rstn     (rstn),
        .rdata    (rdata),
        .bad      (bad),
        .busy     (busy),
        .buf_load (buf_load),
        .buf_sel  (buf_sel),
        .inst     (inst),
        .fault    (fault)
    );

    imem #(
        .MEM_WORDS   (MEM_WORDS),
        .NX_BASE     (NX_BASE),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_imem (
        .clk   (clk),
        .rstn  (rstn),
        .req   (imem_req),
        .addr  (imem_addr),
        .busy  (busy),
        .rdata (rdata),
        .bad   (bad)
    );

    assign page_fault = fault[FAULT_PAGE];
    assign xes_fault  = fault[FAULT_XES];

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam addr_t RESET_PC    = 32'h0000_0000;
    localparam int    MEM_WORDS   = 32;
    localparam addr_t NX_BASE     = 32'h0000_0060;
    localparam int    WAIT_CYCLES = 1;
    localparam addr_t MAP_END     = addr_t'(MEM_WORDS * 4);
    localparam int    IDX_W       = $clog2(MEM_WORDS);

    // Fixed targets for the directed redirects.
    localparam addr_t T_ERET = 32'h0000_0010;
    localparam addr_t T_IRQ  = 32'h0000_0040;
    localparam addr_t T_ALU  = 32'h0000_0024;
    localparam addr_t T_JUMP = 32'h0000_0058;

    logic  clk;
    logic  rstn;
    logic  eret_en;
    addr_t ret_epc;
    logic  irq_en;
    addr_t irq_vec;
    logic  alu_en;
    addr_t alu_target;
    logic  jump_en;
    addr_t jump_target;
    logic  stall;
    addr_t pc;
    inst_t inst;
    logic  inst_valid;
    logic  page_fault;
    logic  xes_fault;

    inst_t rom_model [MEM_WORDS];
    addr_t exp_pc;
    int    errors;
    int    delivered;
    int    redirects;
    addr_t last_pc;
    inst_t last_inst;
    logic  last_page;
    logic  last_xes;

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .MEM_WORDS   (MEM_WORDS),
        .NX_BASE     (NX_BASE),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) DUT (
        .clk         (clk),
        .rstn        (rstn),
        .eret_en     (eret_en),
        .ret_epc     (ret_epc),
        .irq_en      (irq_en),
        .irq_vec     (irq_vec),
        .alu_en      (alu_en),
        .alu_target  (alu_target),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .stall       (stall),
        .pc          (pc),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .page_fault  (page_fault),
        .xes_fault   (xes_fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h (t=%0t)", name, got, exp, $time);
            errors++;
        end
    endtask

    // Unmapped words read as zero.
    function automatic inst_t expected_inst(input addr_t a);
        if (a >= MAP_END) begin
            return '0;
        end
        return rom_model[a[IDX_W+1:2]];
    endfunction

    function automatic logic expected_page(input addr_t a);
        return (a >= MAP_END);
    endfunction

    function automatic logic expected_xes(input addr_t a);
        return (a < MAP_END) && (a >= NX_BASE);
    endfunction

    // Highest priority source wins.
    function automatic addr_t chosen_target();
        if (eret_en) begin
            return ret_epc;
        end
        if (irq_en) begin
            return irq_vec;
        end
        if (alu_en) begin
            return alu_target;
        end
        return jump_target;
    endfunction

    function automatic addr_t random_target();
        int unsigned r;
        r = $urandom % 100;
        if (r < 70) begin
            return addr_t'(($urandom % MEM_WORDS) * 4);
        end
        return MAP_END + addr_t'(($urandom % 16) * 4); // Past the mapped words.
    endfunction

    task automatic observe_outputs();
        logic redir;
        redir = eret_en | irq_en | alu_en | jump_en;
        if (inst_valid) begin
            if (stall) begin
                $display("inst_valid was high while stall was high, pc %h", pc);
                errors++;
            end
            if (redir) begin
                $display("Instruction delivered in a redirect cycle, pc %h", pc);
                errors++;
            end
            check_value("pc", pc, exp_pc);
            check_value("inst", inst, expected_inst(exp_pc));
            check_value("page_fault", 32'(page_fault), 32'(expected_page(exp_pc)));
            check_value("xes_fault", 32'(xes_fault), 32'(expected_xes(exp_pc)));
            last_pc   = pc;
            last_inst = inst;
            last_page = page_fault;
            last_xes  = xes_fault;
            exp_pc    = exp_pc + 32'd4;
            delivered++;
        end
        if (redir) begin
            exp_pc = chosen_target();
        end
    endtask

    // Sample at the rising edge, return at the falling edge to drive.
    task automatic clock_cycle();
        @(posedge clk);
        observe_outputs();
        @(negedge clk);
    endtask

    task automatic wait_deliveries(input int n, input int limit, input string what);
        int start;
        int cycles;
        start  = delivered;
        cycles = 0;
        while (((delivered - start) < n) && (cycles < limit)) begin
            clock_cycle();
            cycles++;
        end
        if ((delivered - start) < n) begin
            $display("Timed out after %0d cycles waiting for %0d deliveries in %s",
                     limit, n, what);
            errors++;
        end
    endtask

    task automatic drive_redirect(input logic [3:0] en, input addr_t t_eret,
                                  input addr_t t_irq, input addr_t t_alu,
                                  input addr_t t_jump);
        ret_epc     = t_eret;
        irq_vec     = t_irq;
        alu_target  = t_alu;
        jump_target = t_jump;
        {eret_en, irq_en, alu_en, jump_en} = en;
        clock_cycle();
        {eret_en, irq_en, alu_en, jump_en} = 4'b0000; // One cycle pulse.
    endtask

    task automatic redirect_and_expect(input logic [3:0] en, input addr_t expected,
                                       input string what);
        drive_redirect(en, T_ERET, T_IRQ, T_ALU, T_JUMP);
        wait_deliveries(1, 50, what);
        check_value("pc", last_pc, expected);
        wait_deliveries(3, 50, what);
    endtask

    task automatic jump_to(input addr_t target, input string what);
        drive_redirect(4'b0001, '0, '0, '0, target);
        wait_deliveries(1, 50, what);
        check_value("pc", last_pc, target);
    endtask

    task automatic random_phase(input int n, input int limit);
        int         start;
        int         cycles;
        logic [3:0] en;
        start  = delivered;
        cycles = 0;
        while (((delivered - start) < n) && (cycles < limit)) begin
            stall = (($urandom % 100) < 30);
            if (($urandom % 100) < 5) begin
                en          = 4'(($urandom % 15) + 1); // Often several sources.
                ret_epc     = random_target();
                irq_vec     = random_target();
                alu_target  = random_target();
                jump_target = random_target();
                {eret_en, irq_en, alu_en, jump_en} = en;
                redirects++;
            end
            clock_cycle();
            {eret_en, irq_en, alu_en, jump_en} = 4'b0000;
            cycles++;
        end
        stall = 1'b0;
        if ((delivered - start) < n) begin
            $display("Timed out after %0d cycles in the random phase", limit);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'hdae7));
        $readmemh("dv/imem.hex", rom_model);
        errors    = 0;
        delivered = 0;
        redirects = 0;
        exp_pc    = RESET_PC;
        rstn      = 1'b0;
        stall     = 1'b0;
        {eret_en, irq_en, alu_en, jump_en} = 4'b0000;
        ret_epc     = '0;
        irq_vec     = '0;
        alu_target  = '0;
        jump_target = '0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("inst_valid", 32'(inst_valid), 32'd0);
        check_value("page_fault", 32'(page_fault), 32'd0);
        check_value("xes_fault", 32'(xes_fault), 32'd0);
        check_value("pc", pc, RESET_PC);
        rstn = 1'b1;

        wait_deliveries(8, 100, "the reset stream");

        // Hold decode off long enough for a word to land in the buffer.
        stall = 1'b1;
        repeat (6) clock_cycle();
        stall = 1'b0;
        wait_deliveries(4, 50, "the stall release");

        redirect_and_expect(4'b1000, T_ERET, "eret redirect");
        redirect_and_expect(4'b0100, T_IRQ, "irq redirect");
        redirect_and_expect(4'b0010, T_ALU, "alu redirect");
        redirect_and_expect(4'b0001, T_JUMP, "jump redirect");

        redirect_and_expect(4'b1111, T_ERET, "all sources");
        redirect_and_expect(4'b0111, T_IRQ, "irq over alu and jump");
        redirect_and_expect(4'b0011, T_ALU, "alu over jump");
        redirect_and_expect(4'b1001, T_ERET, "eret over jump");
        redirect_and_expect(4'b0101, T_IRQ, "irq over jump");

        jump_to(NX_BASE, "the access fault region");
        check_value("xes_fault", 32'(last_xes), 32'd1);
        check_value("inst", last_inst, rom_model[NX_BASE[IDX_W+1:2]]);
        jump_to(MAP_END, "the unmapped region");
        check_value("page_fault", 32'(last_page), 32'd1);
        check_value("inst", last_inst, 32'd0);
        jump_to(MAP_END - 32'd8, "the map boundary");
        wait_deliveries(4, 50, "the map boundary");

        jump_to(32'h0000_0100, "a far unmapped address");
        jump_to(32'h0000_0008, "the return from faults");
        check_value("page_fault", 32'(last_page), 32'd0);
        check_value("xes_fault", 32'(last_xes), 32'd0);
        wait_deliveries(4, 50, "the return from faults");

        random_phase(400, 6000);
        jump_to(RESET_PC, "the final redirect");
        wait_deliveries(4, 50, "the final stream");

        $display("Done: %0d deliveries, %0d random redirects, %0d errors",
                 delivered, redirects, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: dv/imem.hex
// One 32-bit instruction word per line in hex, word address 0 upward.
00000013
00400093
00800113
00c00193
00208233
404182b3
0062f333
0062e3b3
00731463
00a00413
00140413
fe941ee3
00112023
00012483
00448513
0080056f
00000597
01058593
0005a603
00c686b3
40d70733
0017d793
00179813
0107e8b3
00088913
00190993
01399a63
00000a13
001a0a13
00aa1463
30200073
0000006f

// File: src.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/pc_gen.sv
hw/inst_buffer.sv
hw/imem.sv
hw/fetch_top.sv
dv/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
